// File: all.f
+incdir+include
verilog/hal_pkg.sv
verilog/host_link.sv
verilog/cmd_decoder.sv
verilog/pll_cfg_writer.sv
verilog/sync_polarity.sv
verilog/vga_sync_out.sv
verilog/front_panel.sv
verilog/hal_top.sv
tb/tb_hal_top.sv

// File: Bender.yml
package:
  name: hal_top

sources:
  - include_dirs:
      - include
    files:
      - verilog/hal_pkg.sv
      - verilog/host_link.sv
      - verilog/cmd_decoder.sv
      - verilog/pll_cfg_writer.sv
      - verilog/sync_polarity.sv
      - verilog/vga_sync_out.sv
      - verilog/front_panel.sv
      - verilog/hal_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_hal_top.sv

// File: tb/hal_vectors.txt
# Fields in hex. W word, G word, B user_n osd_n key ticks, L pwr disk user act led board,
# S act short long en hs_act hs_idle vs_act vs_idle oe, C cfg, T x8, P addr data, E gp_in, F ready rreq
G 00000000
E 5ca623a4
G 80000000
E 00020000
F 0 0
T 500 6e 28 dc 2d0 5 5 14
S 0 5 14 0 0 1 0 1 1
S 1 5 14 1 0 1 0 1 0
L 2 2 1 0 6 01
L 3 1 0 1 1 14
L 0 0 0 0 3 10
L 1 0 1 1 0 15
B 0 1 3 1
B 1 1 3 a
E 00020000
B 0 1 3 a
E 40020000
B 1 0 3 a
E 20020000
B 1 1 3 a
E 00020000
W 80100001
W 801000a0
W 80000000
C a
P 1f 00000000
P 02 00000000
F 1 0
W 80100020
W 80100780
W 80100058
W 8010002c
W 80100094
W 80100438
W 80100004
W 80100005
W 80100024
W 80100004
W 80105678
W 80101234
P 04 12345678
W 80000000
T 780 58 2c 94 438 4 5 24
W 80100001
W 80100048
W 80000000
C 5
P 02 00000000
F 1 0
G 40000000
F 1 1
G 00000000
G 80000000
F 1 0
S 0 5 14 0 1 1 1 1 1

// File: tb/tb_hal_top.sv
/*
 * HAL top level testbench
 * Replays the vector file against the DUT: host words with the
 * strobe handshake, button levels, LED requests and sync patterns.
 * Checks config, timing, PLL writes, the status word and flags.
 * A responder model answers each PLL management write with a
 * random waitrequest.
 */
module tb_hal_top;
	timeunit 1ns;
	timeprecision 100ps;

	import hal_pkg::*;

	localparam int debounce_div    = 3;
	localparam int cycles_per_line = 200;
	localparam int wait_limit      = 50;
	localparam     vector_path     = "tb/hal_vectors.txt";

	logic          FPGA_CLK2_50;
	logic          resetd;
	logic [31:0]   gp_out;
	logic [31:0]   gp_in;
	logic          btn_user_n;
	logic          btn_osd_n;
	logic [1:0]    key;
	logic [1:0]    led_power_req;
	logic [1:0]    led_disk_req;
	logic          led_user_req;
	panel_led_t    panel_led;
	logic [7:0]    board_led;
	logic          hs_core;
	logic          vs_core;
	logic          vga_en;
	logic          vga_hs;
	logic          vga_vs;
	logic          vga_oe;
	logic          pll_waitrequest;
	pll_mgmt_t     pll_mgmt;
	hal_cfg_t      cfg;
	video_timing_t timing;
	logic          cfg_ready;
	logic          reset_req;

	pll_write_t pll_log[$];
	integer     seed       = 32'h5e7b_708d;
	int         val_errors = 0;
	int         fail_count = 0;
	int         line_count = 0;

	// Debounce model, index 0 user and 1 OSD
	logic [1:0] btn_level = 2'b00;
	logic [1:0] btn_exp   = 2'b00;
	int         btn_run [2];

	hal_top #(
		.debounce_div (debounce_div)
	) hal_top_i (
		.FPGA_CLK2_50    (FPGA_CLK2_50),
		.resetd          (resetd),
		.gp_out          (gp_out),
		.gp_in           (gp_in),
		.btn_user_n      (btn_user_n),
		.btn_osd_n       (btn_osd_n),
		.key             (key),
		.led_power_req   (led_power_req),
		.led_disk_req    (led_disk_req),
		.led_user_req    (led_user_req),
		.panel_led       (panel_led),
		.board_led       (board_led),
		.hs_core         (hs_core),
		.vs_core         (vs_core),
		.vga_en          (vga_en),
		.vga_hs          (vga_hs),
		.vga_vs          (vga_vs),
		.vga_oe          (vga_oe),
		.pll_waitrequest (pll_waitrequest),
		.pll_mgmt        (pll_mgmt),
		.cfg             (cfg),
		.timing          (timing),
		.cfg_ready       (cfg_ready),
		.reset_req       (reset_req)
	);

	initial begin
		FPGA_CLK2_50 = 1'b0;
		forever #2 FPGA_CLK2_50 = ~FPGA_CLK2_50;
	end

	// ========================================
	// PLL management responder
	// ========================================
	initial begin : pll_responder
		int hold;
		pll_waitrequest = 1'b0;
		forever begin
			@(negedge FPGA_CLK2_50);
			if (pll_mgmt.write === 1'b1) begin
				pll_log.push_back(pll_mgmt.word);
				hold = 1 + ($unsigned($random(seed)) % 6);
				pll_waitrequest = 1'b1;
				repeat (hold) @(negedge FPGA_CLK2_50);
				pll_waitrequest = 1'b0;
			end
		end
	end

	// Budget grows with the vector file
	initial begin : watchdog
		wait (line_count > 0);
		repeat (line_count * cycles_per_line) @(posedge FPGA_CLK2_50);
		$display("Watchdog timeout after %0d cycles", line_count * cycles_per_line);
		$display("ERRORS FOUND");
		$finish;
	end

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			val_errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_cfg(input string name, input hal_cfg_t got, input hal_cfg_t exp);
		if (got !== exp) begin
			val_errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_timing(input string name, input video_timing_t got,
		input video_timing_t exp);
		if (got !== exp) begin
			val_errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_pll(input string name, input pll_write_t got, input pll_write_t exp);
		if (got !== exp) begin
			val_errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_led(input string name, input panel_led_t got, input panel_led_t exp);
		if (got !== exp) begin
			val_errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		fail_count++;
		$display("%s", msg);
	endtask

	// ========================================
	// Stimulus
	// ========================================
	// Four-phase strobe, io_clk is bit 17 and io_ack is status bit 16
	task automatic host_write(input logic [31:0] word);
		int cycles;
		@(negedge FPGA_CLK2_50);
		gp_out = word & ~32'h0002_0000;
		repeat (2) @(negedge FPGA_CLK2_50);
		gp_out[17] = 1'b1;
		cycles = 0;
		do begin
			@(negedge FPGA_CLK2_50);
			cycles++;
		end while (!gp_in[16] && cycles < wait_limit);
		if (!gp_in[16])
			report_failure($sformatf("Timeout waiting for io_ack to rise, word %h", word));
		else
			check_word("io_ack latency", cycles, 32'd4);
		gp_out[17] = 1'b0;
		cycles = 0;
		do begin
			@(negedge FPGA_CLK2_50);
			cycles++;
		end while (gp_in[16] && cycles < wait_limit);
		if (gp_in[16])
			report_failure($sformatf("Timeout waiting for io_ack to fall, word %h", word));
	endtask

	task automatic drive_host(input logic [31:0] word);
		@(negedge FPGA_CLK2_50);
		gp_out = word;
		repeat (4) @(negedge FPGA_CLK2_50);
	endtask

	// Eight equal ticks in a row move a debounced button, fewer leave it
	task automatic hold_buttons(input logic user_n, input logic osd_n, input logic [1:0] k,
		input int ticks);
		logic [1:0] pressed;
		pressed[0] = !user_n || !k[1];
		pressed[1] = !osd_n || !k[0];
		for (int i = 0; i < 2; i++) begin
			btn_run[i]   = (pressed[i] == btn_level[i]) ? btn_run[i] + ticks : ticks;
			btn_level[i] = pressed[i];
			if (btn_run[i] >= 8)
				btn_exp[i] = pressed[i];
		end
		@(negedge FPGA_CLK2_50);
		btn_user_n = user_n;
		btn_osd_n  = osd_n;
		key        = k;
		repeat (ticks * (debounce_div + 1)) @(negedge FPGA_CLK2_50);
		// Status bits only show while gp_out bit 31 is set
		if (gp_out[31])
			check_word("gp_in[30:29]", {30'd0, gp_in[30:29]},
				{30'd0, btn_exp[0], btn_exp[1]});
	endtask

	task automatic drive_leds(input logic [1:0] pwr, input logic [1:0] disk, input logic user,
		input logic act, input logic [2:0] exp_led, input logic [7:0] exp_board);
		@(negedge FPGA_CLK2_50);
		led_power_req = pwr;
		led_disk_req  = disk;
		led_user_req  = user;
		// host_act comes straight from gp_out bit 29
		gp_out[29]    = act;
		#1;
		check_led("panel_led", panel_led, exp_led);
		check_word("board_led", board_led, exp_board);
	endtask

	task automatic sync_phase(input logic level, input int len, input logic check,
		input logic exp_hs, input logic exp_vs);
		repeat (len) begin
			@(negedge FPGA_CLK2_50);
			hs_core = level;
			vs_core = level;
			if (check) begin
				#1;
				check_word("vga_hs", vga_hs, exp_hs);
				check_word("vga_vs", vga_vs, exp_vs);
			end
		end
	endtask

	// Three periods to settle, one checked
	task automatic run_sync(input logic act, input int short_len, input int long_len,
		input logic en, input logic hs_act, input logic hs_idle, input logic vs_act,
		input logic vs_idle, input logic exp_oe);
		@(negedge FPGA_CLK2_50);
		vga_en = en;
		repeat (3) begin
			sync_phase(act, short_len, 1'b0, 1'b0, 1'b0);
			sync_phase(~act, long_len, 1'b0, 1'b0, 1'b0);
		end
		sync_phase(act, short_len, 1'b1, hs_act, vs_act);
		sync_phase(~act, long_len, 1'b1, hs_idle, vs_idle);
		check_word("vga_oe", vga_oe, exp_oe);
	endtask

	task automatic expect_pll_write(input logic [5:0] addr, input logic [31:0] data);
		int         waited;
		pll_write_t exp_w;
		pll_write_t got;
		exp_w.address = addr;
		exp_w.data    = data;
		waited = 0;
		while (pll_log.size() == 0 && waited < wait_limit) begin
			@(negedge FPGA_CLK2_50);
			waited++;
		end
		if (pll_log.size() == 0) begin
			report_failure($sformatf("Missing PLL write to address %h", addr));
		end else begin
			got = pll_log.pop_front();
			check_pll("pll_mgmt.word", got, exp_w);
		end
	endtask

	// Let the last write finish before reading the flags
	task automatic expect_flags(input logic ready, input logic rreq);
		int waited;
		waited = 0;
		@(negedge FPGA_CLK2_50);
		while (pll_waitrequest && waited < wait_limit) begin
			@(negedge FPGA_CLK2_50);
			waited++;
		end
		repeat (4) @(negedge FPGA_CLK2_50);
		check_word("cfg_ready", cfg_ready, ready);
		check_word("reset_req", reset_req, rreq);
	endtask

	// ========================================
	// Vector file
	// ========================================
	task automatic count_lines(output int n);
		integer           fd;
		logic [8*160-1:0] line_buf;
		n  = 0;
		fd = $fopen(vector_path, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				if ($fgets(line_buf, fd) != 0)
					n++;
			end
			$fclose(fd);
		end
	endtask

	function automatic int field_count(input logic [63:0] op);
		case (op)
			"B":      return 4;
			"L":      return 6;
			"S":      return 9;
			"T":      return 8;
			"P", "F": return 2;
			default:  return 1;
		endcase
	endfunction

	task run_vectors(input integer fd);
		logic [63:0]      op;
		logic [31:0]      f [9];
		logic [8*160-1:0] rest;
		integer           code;
		logic             done;
		video_timing_t    exp_t;
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, "%s", op);
			if (code != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				code = $fgets(rest, fd);
			end else begin
				for (int i = 0; i < field_count(op); i++)
					code = $fscanf(fd, "%h", f[i]);
				case (op)
					"W": host_write(f[0]);
					"G": drive_host(f[0]);
					"B": hold_buttons(f[0][0], f[1][0], f[2][1:0], f[3]);
					"L": drive_leds(f[0][1:0], f[1][1:0], f[2][0], f[3][0], f[4][2:0],
						f[5][7:0]);
					"S": run_sync(f[0][0], f[1], f[2], f[3][0], f[4][0], f[5][0], f[6][0],
						f[7][0], f[8][0]);
					"C": begin
						@(negedge FPGA_CLK2_50);
						check_cfg("cfg", cfg, f[0][3:0]);
					end
					"T": begin
						exp_t.width  = f[0][11:0];
						exp_t.hfp    = f[1][11:0];
						exp_t.hs     = f[2][11:0];
						exp_t.hbp    = f[3][11:0];
						exp_t.height = f[4][11:0];
						exp_t.vfp    = f[5][11:0];
						exp_t.vs     = f[6][11:0];
						exp_t.vbp    = f[7][11:0];
						@(negedge FPGA_CLK2_50);
						check_timing("timing", timing, exp_t);
					end
					"P": expect_pll_write(f[0][5:0], f[1]);
					"E": begin
						@(negedge FPGA_CLK2_50);
						check_word("gp_in", gp_in, f[0]);
					end
					"F": expect_flags(f[0][0], f[1][0]);
					default: report_failure($sformatf("Unknown vector op %0s", op));
				endcase
			end
		end
	endtask

	initial begin : main
		integer fd;
		resetd        = 1'b1;
		gp_out        = 32'd0;
		btn_user_n    = 1'b1;
		btn_osd_n     = 1'b1;
		key           = 2'b11;
		led_power_req = 2'd0;
		led_disk_req  = 2'd0;
		led_user_req  = 1'b0;
		hs_core       = 1'b0;
		vs_core       = 1'b0;
		vga_en        = 1'b0;
		count_lines(line_count);
		repeat (2) @(negedge FPGA_CLK2_50);
		resetd = 1'b0;
		fd = $fopen(vector_path, "r");
		if (fd == 0) begin
			$display("Cannot open the vector file %0s", vector_path);
			$display("ERRORS FOUND");
			$finish;
		end else begin
			run_vectors(fd);
			$fclose(fd);
			repeat (20) @(negedge FPGA_CLK2_50);
			if (pll_log.size() != 0)
				report_failure($sformatf("%0d PLL writes more than expected", pll_log.size()));
			$display("Value errors: %0d, other failures: %0d", val_errors, fail_count);
			if (val_errors == 0 && fail_count == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
			$finish;
		end
	end

endmodule

// File: verilog/hal_top.sv
/*
 * HAL top level
 * Board glue between the host link, command decoder, PLL
 * configuration writer, front panel and VGA sync output.
 */
`include "hal_macros.svh"

module hal_top #(
	parameter int debounce_div = `HAL_DEBOUNCE_DIV
) (
	input  logic                   FPGA_CLK2_50,
	input  logic                   resetd,
	input  logic [31:0]            gp_out,
	output logic [31:0]            gp_in,
	input  logic                   btn_user_n,
	input  logic                   btn_osd_n,
	input  logic [1:0]             key,
	input  logic [1:0]             led_power_req,
	input  logic [1:0]             led_disk_req,
	input  logic                   led_user_req,
	output hal_pkg::panel_led_t    panel_led,
	output logic [7:0]             board_led,
	input  logic                   hs_core,
	input  logic                   vs_core,
	input  logic                   vga_en,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   vga_oe,
	input  logic                   pll_waitrequest,
	output hal_pkg::pll_mgmt_t     pll_mgmt,
	output hal_pkg::hal_cfg_t      cfg,
	output hal_pkg::video_timing_t timing,
	output logic                   cfg_ready,
	output logic                   reset_req
);
	import hal_pkg::*;

	host_word_t host_word;
	pll_write_t pll_param;
	logic       io_strobe;
	logic       btn_user;
	logic       btn_osd;
	logic       cfg_got;
	logic       cfg_custom;
	logic       pll_req;
	logic       pll_ack;

	// ========================================
	// Input side
	// ========================================
	host_link host_link_i (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.gp_out       (gp_out),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.host_word    (host_word),
		.io_strobe    (io_strobe),
		.gp_in        (gp_in),
		.reset_req    (reset_req)
	);

	front_panel #(
		.debounce_div (debounce_div)
	) front_panel_i (
		.FPGA_CLK2_50  (FPGA_CLK2_50),
		.resetd        (resetd),
		.btn_user_n    (btn_user_n),
		.btn_osd_n     (btn_osd_n),
		.key           (key),
		.led_power_req (led_power_req),
		.led_disk_req  (led_disk_req),
		.led_user_req  (led_user_req),
		.host_act      (gp_out[29]),
		.btn_user      (btn_user),
		.btn_osd       (btn_osd),
		.panel_led     (panel_led),
		.board_led     (board_led)
	);

	// ========================================
	// Configuration path
	// ========================================
	cmd_decoder cmd_decoder_i (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.host_word    (host_word),
		.io_strobe    (io_strobe),
		.cfg          (cfg),
		.timing       (timing),
		.cfg_got      (cfg_got),
		.cfg_custom   (cfg_custom),
		.pll_req      (pll_req),
		.pll_param    (pll_param),
		.pll_ack      (pll_ack)
	);

	pll_cfg_writer pll_cfg_writer_i (
		.FPGA_CLK2_50    (FPGA_CLK2_50),
		.resetd          (resetd),
		.cfg_got         (cfg_got),
		.cfg_custom      (cfg_custom),
		.pll_req         (pll_req),
		.pll_param       (pll_param),
		.pll_ack         (pll_ack),
		.pll_waitrequest (pll_waitrequest),
		.pll_mgmt        (pll_mgmt),
		.cfg_ready       (cfg_ready)
	);

	// Output side
	vga_sync_out vga_sync_out_i (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.hs_core      (hs_core),
		.vs_core      (vs_core),
		.cfg          (cfg),
		.vga_en       (vga_en),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs),
		.vga_oe       (vga_oe)
	);

endmodule

// File: verilog/front_panel.sv
/*
 * Front panel
 * Debounces the user and OSD buttons on a slow sample tick and
 * drives the panel and board LEDs from the core requests.
 */
`include "hal_macros.svh"

module front_panel #(
	parameter int debounce_div = `HAL_DEBOUNCE_DIV
) (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  logic                btn_user_n,
	input  logic                btn_osd_n,
	input  logic [1:0]          key,
	input  logic [1:0]          led_power_req,
	input  logic [1:0]          led_disk_req,
	input  logic                led_user_req,
	input  logic                host_act,
	output logic                btn_user,
	output logic                btn_osd,
	output hal_pkg::panel_led_t panel_led,
	output logic [7:0]          board_led
);
	localparam int div_w = $clog2(debounce_div + 2);

	logic [div_w-1:0] div_cnt;
	logic             tick;
	logic [1:0]       btn_raw;
	logic [1:0][7:0]  hist;
	logic [1:0][7:0]  hist_nxt;
	logic [1:0]       btn_q;

	// ========================================
	// Buttons
	// ========================================
	assign tick = (div_cnt == '0);

	// Index 0 user, index 1 OSD
	assign btn_raw[0] = ~(btn_user_n & key[1]);
	assign btn_raw[1] = ~(btn_osd_n & key[0]);

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd || div_cnt == div_w'(debounce_div))
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_comb begin
		for (int i = 0; i < 2; i++)
			hist_nxt[i] = {hist[i][6:0], btn_raw[i]};
	end

	// Eight equal samples in a row change the state
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			hist  <= '0;
			btn_q <= '0;
		end else if (tick) begin
			hist <= hist_nxt;
			for (int i = 0; i < 2; i++) begin
				if (&hist_nxt[i])
					btn_q[i] <= 1'b1;
				else if (hist_nxt[i] == 8'd0)
					btn_q[i] <= 1'b0;
			end
		end
	end

	assign btn_user = btn_q[0];
	assign btn_osd  = btn_q[1];

	// ========================================
	// LEDs
	// ========================================
	assign panel_led.power = led_power_req[1] & ~led_power_req[0];
	// Host activity flashes the disk LED unless the core owns it
	assign panel_led.hdd   = led_disk_req[1] ? ~led_disk_req[0] :
		~(led_disk_req[0] | host_act);
	assign panel_led.user  = ~led_user_req;

	// Board LEDs light on a low level
	assign board_led = {3'b000, ~panel_led.power, 1'b0, ~panel_led.hdd, 1'b0, ~panel_led.user};

endmodule

// File: verilog/vga_sync_out.sv
/*
 * VGA sync output
 * Normalizes both core syncs to active-high pulses and drives
 * the VGA connector sync pins, separate or composite.
 */
module vga_sync_out (
	input  logic              FPGA_CLK2_50,
	input  logic              resetd,
	input  logic              hs_core,
	input  logic              vs_core,
	input  hal_pkg::hal_cfg_t cfg,
	input  logic              vga_en,
	output logic              vga_hs,
	output logic              vga_vs,
	output logic              vga_oe
);
	logic hs_pulse;
	logic vs_pulse;

	sync_polarity sync_h (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_raw     (hs_core),
		.sync_high    (hs_pulse)
	);

	sync_polarity sync_v (
		.FPGA_CLK2_50 (FPGA_CLK2_50),
		.resetd       (resetd),
		.sync_raw     (vs_core),
		.sync_high    (vs_pulse)
	);

	// Connector syncs are active low
	// Composite carries both on hsync and parks vsync high
	assign vga_hs = cfg.csync ? ~(hs_pulse ^ vs_pulse) : ~hs_pulse;
	assign vga_vs = cfg.csync ? 1'b1 : ~vs_pulse;

	// Buffer enable is active low
	assign vga_oe = ~vga_en;

endmodule

// File: verilog/sync_polarity.sv
/*
 * Sync polarity normalizer
 * Measures the high and low phases of a sync signal and inverts
 * it when the high phase is longer, so the pulse is always the
 * short phase, active high.
 */
module sync_polarity #(
	parameter int cnt_w = 20
) (
	input  logic FPGA_CLK2_50,
	input  logic resetd,
	input  logic sync_raw,
	output logic sync_high
);
	logic             s1;
	logic             s2;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] len_high;
	logic [cnt_w-1:0] len_low;
	logic             pol;

	assign sync_high = sync_raw ^ pol;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			cnt      <= '0;
			len_high <= '0;
			len_low  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= sync_raw;
			s2 <= s1;
			// Rising edge closes a low phase, falling edge a high one
			if (s1 && !s2)
				len_low <= cnt;
			if (!s1 && s2)
				len_high <= cnt;
			if (s1 != s2)
				cnt <= '0;
			else if (!(&cnt))
				cnt <= cnt + 1'b1;
			pol <= (len_high > len_low);
		end
	end

endmodule

// File: verilog/pll_cfg_writer.sv
/*
 * PLL configuration writer
 * Drives the PLL management write port. Runs the mode/start
 * sequence when cfg_got rises and serves custom parameter
 * requests in between. Each write waits for waitrequest to fall.
 */
`include "hal_macros.svh"

module pll_cfg_writer (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  logic                cfg_got,
	input  logic                cfg_custom,
	input  logic                pll_req,
	input  hal_pkg::pll_write_t pll_param,
	output logic                pll_ack,
	input  logic                pll_waitrequest,
	output hal_pkg::pll_mgmt_t  pll_mgmt,
	output logic                cfg_ready
);
	import hal_pkg::*;

	localparam pll_write_t mode_word  = '{address: `HAL_PLL_ADDR_MODE, data: 32'd0};
	localparam pll_write_t start_word = '{address: `HAL_PLL_ADDR_START, data: 32'd0};

	typedef enum logic [2:0] {
		st_idle,
		st_mode_wait,
		st_start_wait,
		st_cust_wait,
		st_ack
	} state_t;

	state_t state;
	logic   got_d;
	logic   got_pend;
	logic   wait_d;
	logic   wait_fall;

	assign wait_fall = wait_d & ~pll_waitrequest;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			state          <= st_idle;
			got_d          <= 1'b0;
			got_pend       <= 1'b0;
			wait_d         <= 1'b0;
			pll_mgmt.write <= 1'b0;
			pll_ack        <= 1'b0;
			cfg_ready      <= 1'b0;
		end else begin
			got_d          <= cfg_got;
			wait_d         <= pll_waitrequest;
			pll_mgmt.write <= 1'b0;
			case (state)
				st_idle: begin
					if (got_pend) begin
						got_pend       <= 1'b0;
						pll_mgmt.write <= 1'b1;
						// Custom parameters keep their own mode
						if (!cfg_custom) begin
							pll_mgmt.word <= mode_word;
							state         <= st_mode_wait;
						end else begin
							pll_mgmt.word <= start_word;
							state         <= st_start_wait;
						end
					end else if (pll_req) begin
						pll_mgmt.write <= 1'b1;
						pll_mgmt.word  <= pll_param;
						state          <= st_cust_wait;
					end
				end
				st_mode_wait: begin
					if (wait_fall) begin
						pll_mgmt.write <= 1'b1;
						pll_mgmt.word  <= start_word;
						state          <= st_start_wait;
					end
				end
				st_start_wait: begin
					if (wait_fall) begin
						cfg_ready <= 1'b1;
						state     <= st_idle;
					end
				end
				st_cust_wait: begin
					if (wait_fall) begin
						pll_ack <= 1'b1;
						state   <= st_ack;
					end
				end
				st_ack: begin
					if (!pll_req) begin
						pll_ack <= 1'b0;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
			// A rise during a busy write waits its turn
			if (cfg_got && !got_d)
				got_pend <= 1'b1;
		end
	end

endmodule

// File: verilog/cmd_decoder.sv
/*
 * Host command decoder
 * Opens a command on the first strobe with io_uio high, then
 * loads the config word, the video timing set and custom PLL
 * parameter triplets. Each triplet goes to the PLL writer
 * through a four-phase req/ack.
 */
`include "hal_macros.svh"

module cmd_decoder (
	input  logic                   FPGA_CLK2_50,
	input  logic                   resetd,
	input  hal_pkg::host_word_t    host_word,
	input  logic                   io_strobe,
	output hal_pkg::hal_cfg_t      cfg,
	output hal_pkg::video_timing_t timing,
	output logic                   cfg_got,
	output logic                   cfg_custom,
	output logic                   pll_req,
	output hal_pkg::pll_write_t    pll_param,
	input  logic                   pll_ack
);
	import hal_pkg::*;

	// 1280x720@60 CEA
	localparam video_timing_t timing_default = '{
		width:  12'd1280, hfp: 12'd110, hs: 12'd40, hbp: 12'd220,
		height: 12'd720,  vfp: 12'd5,   vs: 12'd5,  vbp: 12'd20
	};

	logic                     has_cmd;
	logic [7:0]               cmd;
	logic [3:0]               word_cnt;
	logic [1:0]               role;
	logic [5:0]               param_addr;
	logic [15:0]              data_lo;
	logic [`HAL_TIMING_W-1:0] din_t;

	assign din_t = host_word.io_din[`HAL_TIMING_W-1:0];

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			has_cmd    <= 1'b0;
			cmd        <= 8'd0;
			word_cnt   <= 4'd0;
			role       <= 2'd0;
			cfg        <= '0;
			timing     <= timing_default;
			cfg_got    <= 1'b0;
			cfg_custom <= 1'b0;
			pll_req    <= 1'b0;
		end else begin
			// Writer has the triplet
			if (pll_req && pll_ack)
				pll_req <= 1'b0;

			if (!host_word.io_uio) begin
				has_cmd <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					has_cmd  <= 1'b1;
					cmd      <= host_word.io_din[7:0];
					word_cnt <= 4'd0;
					role     <= 2'd0;
				end else if (cmd == `HAL_CMD_CFG) begin
					cfg.dvi_mode  <= host_word.io_din[7];
					cfg.audio_96k <= host_word.io_din[6];
					cfg.ypbpr_en  <= host_word.io_din[5];
					cfg.csync     <= host_word.io_din[3];
					cfg_got       <= 1'b1;
				end else if (cmd == `HAL_CMD_VIDEO) begin
					// New video setup, mode sequence reruns on next config
					cfg_got <= 1'b0;
					if (word_cnt < 4'd8) begin
						word_cnt <= word_cnt + 4'd1;
						case (word_cnt[2:0])
							3'd0: timing.width  <= din_t;
							3'd1: timing.hfp    <= din_t;
							3'd2: timing.hs     <= din_t;
							3'd3: timing.hbp    <= din_t;
							3'd4: timing.height <= din_t;
							3'd5: timing.vfp    <= din_t;
							3'd6: timing.vs     <= din_t;
							default: timing.vbp <= din_t;
						endcase
					end else begin
						// Triplets: address, data low, data high
						case (role)
							2'd0: begin
								param_addr <= host_word.io_din[5:0];
								role       <= 2'd1;
							end
							2'd1: begin
								data_lo <= host_word.io_din;
								role    <= 2'd2;
							end
							default: begin
								pll_param.address <= param_addr;
								pll_param.data    <= {host_word.io_din, data_lo};
								cfg_custom        <= 1'b1;
								pll_req           <= 1'b1;
								role              <= 2'd0;
							end
						endcase
					end
				end
			end
		end
	end

endmodule

// File: verilog/host_link.sv
/*
 * Host link
 * Synchronizes the host output word, runs the four-phase strobe
 * acknowledge and builds the status word read back by the host.
 * Also latches the reset request coded on host bits 31:30.
 */
`include "hal_macros.svh"

module host_link (
	input  logic                FPGA_CLK2_50,
	input  logic                resetd,
	input  logic [31:0]         gp_out,
	input  logic                btn_user,
	input  logic                btn_osd,
	output hal_pkg::host_word_t host_word,
	output logic                io_strobe,
	output logic [31:0]         gp_in,
	output logic                reset_req
);
	import hal_pkg::*;

	host_word_t gp_outd;
	logic       rack;
	logic       io_ack;
	logic [1:0] rst_prev;

	// One-cycle pulse on the rising strobe
	assign io_strobe = host_word.io_clk & ~rack;

	// Magic until the host sets bit 31
	assign gp_in = gp_out[31] ?
		{1'b0, btn_user, btn_osd, 10'd0, `HAL_IO_VER, io_ack, 16'd0} : `HAL_CORE_MAGIC;

	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			gp_outd   <= '0;
			host_word <= '0;
			rack      <= 1'b0;
			io_ack    <= 1'b0;
		end else begin
			gp_outd   <= gp_out;
			host_word <= gp_outd;
			// Ack trails io_clk by two flops
			rack      <= host_word.io_clk;
			io_ack    <= rack;
		end
	end

	// Code 1 sets, code 2 right after code 0 clears
	always_ff @(posedge FPGA_CLK2_50) begin
		if (resetd) begin
			rst_prev  <= 2'd0;
			reset_req <= 1'b0;
		end else begin
			rst_prev <= host_word.rst_code;
			if (host_word.rst_code == 2'd1)
				reset_req <= 1'b1;
			else if (host_word.rst_code == 2'd2 && rst_prev == 2'd0)
				reset_req <= 1'b0;
		end
	end

endmodule

// File: verilog/hal_pkg.sv
/*
 * HAL shared types
 * Packed structs for the host word, core configuration, video
 * timing, PLL management writes and the front panel LEDs.
 */
`include "hal_macros.svh"

package hal_pkg;

	// Host output word after synchronization
	typedef struct packed {
		logic [1:0]  rst_code;
		logic [8:0]  spare_hi;
		logic        io_uio;
		logic        io_osd;
		logic        io_fpga;
		logic        io_clk;
		logic        spare_lo;
		logic [15:0] io_din;
	} host_word_t;

	// Config word bits 7, 6, 5 and 3
	typedef struct packed {
		logic dvi_mode;
		logic audio_96k;
		logic ypbpr_en;
		logic csync;
	} hal_cfg_t;

	typedef struct packed {
		logic [`HAL_TIMING_W-1:0] width;
		logic [`HAL_TIMING_W-1:0] hfp;
		logic [`HAL_TIMING_W-1:0] hs;
		logic [`HAL_TIMING_W-1:0] hbp;
		logic [`HAL_TIMING_W-1:0] height;
		logic [`HAL_TIMING_W-1:0] vfp;
		logic [`HAL_TIMING_W-1:0] vs;
		logic [`HAL_TIMING_W-1:0] vbp;
	} video_timing_t;

	typedef struct packed {
		logic [5:0]  address;
		logic [31:0] data;
	} pll_write_t;

	typedef struct packed {
		logic       write;
		pll_write_t word;
	} pll_mgmt_t;

	// Each bit set when that LED is lit
	typedef struct packed {
		logic power;
		logic hdd;
		logic user;
	} panel_led_t;

endpackage

// File: include/hal_macros.svh
/*
 * HAL constants
 * Core identification, host command codes, PLL management
 * addresses and the front panel debounce divider.
 */
`ifndef HAL_MACROS_SVH
`define HAL_MACROS_SVH

// ========================================
// Host identification
// ========================================
// Host reads this while bit 31 of its output word is low
`define HAL_CORE_MAGIC     32'h5CA6_23A4
// Optimized host I/O protocol
`define HAL_IO_VER         2'd1

// Commands opened by the first word with io_uio high
`define HAL_CMD_CFG        8'h01
`define HAL_CMD_VIDEO      8'h20

// ========================================
// PLL management port
// ========================================
`define HAL_PLL_ADDR_MODE  6'd31
`define HAL_PLL_ADDR_START 6'd2

// Front panel sample tick, in clock cycles minus one
`define HAL_DEBOUNCE_DIV   100000
`define HAL_TIMING_W       12

`endif
